// File: fpu_mult_pkg.sv
package fpu_mult_pkg;

    ////////////////////////////////////////
    // Binary32 format constants
    ////////////////////////////////////////

    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    localparam int BIAS   = 127;

    // Field split of a single-precision word
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp32_fields_t;

    // Same 32 bits read raw or as fields
    typedef union packed {
        logic [EXP_W+FRAC_W:0] raw;
        fp32_fields_t          fields;
    } fp32_u;

    // Rounding direction
    typedef enum logic [1:0] {
        RM_NEAREST_EVEN = 2'b00,
        RM_TO_ZERO      = 2'b01,
        RM_TO_POS       = 2'b10,
        RM_TO_NEG       = 2'b11
    } round_mode_e;

    ////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////

    // Captured operands, hidden one restored
    typedef struct packed {
        logic              sign;
        logic              zero;
        logic [EXP_W-1:0]  exp_x;
        logic [EXP_W-1:0]  exp_y;
        logic [FRAC_W:0]   sgf_x;
        logic [FRAC_W:0]   sgf_y;
    } operand_t;

    // Rounded fraction plus exponent corrections
    typedef struct packed {
        logic [FRAC_W-1:0] frac;
        // Product was in [2,4), shifted right by one
        logic              carry_norm;
        // Increment wrapped significand to 2.0
        logic              round_carry;
    } round_res_t;

endpackage

// File: fpu_operand_stage.sv
module fpu_operand_stage (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      load_i,
    input  logic [31:0]               data_x_i,
    input  logic [31:0]               data_y_i,
    input  fpu_mult_pkg::round_mode_e round_mode_i,
    output fpu_mult_pkg::operand_t    op_o,
    output fpu_mult_pkg::round_mode_e round_mode_o
);

    // Operand words as captured
    fpu_mult_pkg::fp32_u word_x;
    fpu_mult_pkg::fp32_u word_y;

    ////////////////////////////////////////
    // Capture on start
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            word_x.raw   <= '0;
            word_y.raw   <= '0;
            round_mode_o <= fpu_mult_pkg::RM_NEAREST_EVEN;
        end else if (load_i) begin
            word_x.raw   <= data_x_i;
            word_y.raw   <= data_y_i;
            round_mode_o <= round_mode_i;
        end
    end

    ////////////////////////////////////////
    // Classify and unpack
    ////////////////////////////////////////

    always_comb begin
        // Result sign
        op_o.sign  = word_x.fields.sign ^ word_y.fields.sign;
        // Zero exponent field covers zero and subnormal, both flushed
        op_o.zero  = (word_x.fields.exp == '0) || (word_y.fields.exp == '0);
        op_o.exp_x = word_x.fields.exp;
        op_o.exp_y = word_y.fields.exp;
        // Hidden one in front of each fraction
        op_o.sgf_x = {1'b1, word_x.fields.frac};
        op_o.sgf_y = {1'b1, word_y.fields.frac};
    end

endmodule

// File: fpu_exp_unit.sv
module fpu_exp_unit (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                load_i,
    input  fpu_mult_pkg::operand_t              op_i,
    input  fpu_mult_pkg::round_res_t            res_i,
    output logic [fpu_mult_pkg::EXP_W-1:0]      exp_o,
    output logic                                overflow_o,
    output logic                                underflow_o
);

    // Two guard bits above the exponent, top one acts as sign
    logic signed [9:0] exp_sum;
    logic              ovf_next;
    logic              unf_next;

    ////////////////////////////////////////
    // Exponent arithmetic
    ////////////////////////////////////////

    always_comb begin
        // ex + ey - bias, then normalise and round corrections
        exp_sum = {2'b00, op_i.exp_x} + {2'b00, op_i.exp_y}
                - 10'(fpu_mult_pkg::BIAS)
                + {9'd0, res_i.carry_norm}
                + {9'd0, res_i.round_carry};

        // All-ones field or above is out of range
        ovf_next = !op_i.zero && (exp_sum >= 10'sd255);
        // Zero or negative lands below normal range
        unf_next = !op_i.zero && (exp_sum <= 10'sd0);
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exp_o       <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else if (load_i) begin
            // Low bits only, flags cover the rest
            exp_o       <= exp_sum[fpu_mult_pkg::EXP_W-1:0];
            overflow_o  <= ovf_next;
            underflow_o <= unf_next;
        end
    end

endmodule

// File: fpu_sgf_multiplier.sv
module fpu_sgf_multiplier (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        start_i,
    input  logic [23:0] sgf_x_i,
    input  logic [23:0] sgf_y_i,
    output logic [47:0] product_o,
    output logic        done_o
);

    // Step counter and run flag
    logic [4:0]  step_cnt;
    logic        busy;

    // Datapath registers
    logic [47:0] acc;
    logic [47:0] mcand;
    logic [23:0] mplier;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    // Start edge already consumes bit 0
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy     <= 1'b1;
                step_cnt <= 5'd1;
            end else if (busy) begin
                step_cnt <= step_cnt + 5'd1;
                // Bit 23 is the 24th and last step
                if (step_cnt == 5'd23) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Shift-add datapath
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start_i) begin
            // First partial product straight from the inputs
            acc    <= sgf_y_i[0] ? {24'd0, sgf_x_i} : 48'd0;
            mcand  <= {23'd0, sgf_x_i, 1'b0};
            mplier <= {1'b0, sgf_y_i[23:1]};
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= {mcand[46:0], 1'b0};
            mplier <= {1'b0, mplier[23:1]};
        end
    end

    // Held until next start
    assign product_o = acc;

endmodule

// File: fpu_norm_round.sv
module fpu_norm_round (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      load_i,
    input  logic [47:0]               product_i,
    input  logic                      sign_i,
    input  fpu_mult_pkg::round_mode_e round_mode_i,
    output fpu_mult_pkg::round_res_t  res_o
);

    logic        shift;
    logic [23:0] sgf_kept;
    logic        guard;
    logic        sticky;
    logic        inexact;
    logic        round_up;
    // One bit wider to catch the wrap to 2.0
    logic [24:0] sgf_inc;

    ////////////////////////////////////////
    // Normalise
    ////////////////////////////////////////

    always_comb begin
        // Product of two [1,2) values sits in [1,4)
        shift = product_i[47];
        if (shift) begin
            sgf_kept = product_i[47:24];
            guard    = product_i[23];
            sticky   = |product_i[22:0];
        end else begin
            sgf_kept = product_i[46:23];
            guard    = product_i[22];
            sticky   = |product_i[21:0];
        end
        inexact = guard | sticky;
    end

    ////////////////////////////////////////
    // Round decision and increment
    ////////////////////////////////////////

    always_comb begin
        round_up = 1'b0;
        case (round_mode_i)
            // Ties go to even lsb
            fpu_mult_pkg::RM_NEAREST_EVEN: round_up = guard & (sticky | sgf_kept[0]);
            fpu_mult_pkg::RM_TO_ZERO:      round_up = 1'b0;
            // Away from zero only on the matching sign
            fpu_mult_pkg::RM_TO_POS:       round_up = !sign_i & inexact;
            fpu_mult_pkg::RM_TO_NEG:       round_up = sign_i & inexact;
            default:                       round_up = 1'b0;
        endcase

        sgf_inc = {1'b0, sgf_kept} + {24'd0, round_up};
    end

    // Result one cycle after load
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_o <= '0;
        end else if (load_i) begin
            // Wrap to 2.0 already leaves the low bits clear and carries into the exponent
            res_o.frac        <= sgf_inc[22:0];
            res_o.carry_norm  <= shift;
            res_o.round_carry <= sgf_inc[24];
        end
    end

endmodule

// File: fpu_result_pack.sv
module fpu_result_pack (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        load_i,
    input  logic        sign_i,
    input  logic        zero_i,
    input  logic [7:0]  exp_i,
    input  logic [22:0] frac_i,
    input  logic        overflow_i,
    input  logic        underflow_i,
    output logic [31:0] result_o,
    output logic        overflow_o,
    output logic        underflow_o
);

    fpu_mult_pkg::fp32_u word;

    ////////////////////////////////////////
    // Final word select
    ////////////////////////////////////////

    always_comb begin
        word.fields.sign = sign_i;
        if (zero_i) begin
            // Signed zero from a zero operand
            word.fields.exp  = '0;
            word.fields.frac = '0;
        end else if (overflow_i) begin
            // Saturate to signed infinity
            word.fields.exp  = '1;
            word.fields.frac = '0;
        end else if (underflow_i) begin
            // Flush to signed zero
            word.fields.exp  = '0;
            word.fields.frac = '0;
        end else begin
            word.fields.exp  = exp_i;
            word.fields.frac = frac_i;
        end
    end

    // Held until next load
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_o    <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else if (load_i) begin
            result_o    <= word.raw;
            overflow_o  <= overflow_i;
            underflow_o <= underflow_i;
        end
    end

endmodule

// File: fpu_mult_ctrl.sv
module fpu_mult_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic beg_i,
    input  logic ack_i,
    input  logic zero_i,
    input  logic mul_done_i,
    output logic load_op_o,
    output logic mul_start_o,
    output logic norm_load_o,
    output logic exp_load_o,
    output logic pack_load_o,
    output logic ready_o
);

    typedef enum logic [2:0] {
        IDLE,
        START,
        MUL_WAIT,
        NORM,
        EXP,
        PACK,
        DONE
    } state_e;

    state_e state;
    state_e state_next;

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            // beg_i only seen here, so busy and DONE ignore it
            IDLE:     if (beg_i) state_next = START;
            // Zero operand skips multiply and round
            START:    state_next = zero_i ? EXP : MUL_WAIT;
            MUL_WAIT: if (mul_done_i) state_next = NORM;
            NORM:     state_next = EXP;
            EXP:      state_next = PACK;
            PACK:     state_next = DONE;
            // Result held until acknowledged
            DONE:     if (ack_i) state_next = IDLE;
            default:  state_next = IDLE;
        endcase
    end

    ////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////

    // Operands sampled on the same edge as beg_i
    assign load_op_o   = (state == IDLE) && beg_i;
    assign mul_start_o = (state == START) && !zero_i;
    assign norm_load_o = (state == NORM);
    assign exp_load_o  = (state == EXP);
    assign pack_load_o = (state == PACK);

    // Handshake out
    assign ready_o     = (state == DONE);

endmodule

// File: fpu_mult_top.sv
module fpu_mult_top (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      beg_i,
    input  logic                      ack_i,
    input  logic [31:0]               data_x_i,
    input  logic [31:0]               data_y_i,
    input  fpu_mult_pkg::round_mode_e round_mode_i,
    output logic [31:0]               result_o,
    output logic                      overflow_o,
    output logic                      underflow_o,
    output logic                      ready_o
);

    // Controller strobes
    logic load_op;
    logic mul_start;
    logic mul_done;
    logic norm_load;
    logic exp_load;
    logic pack_load;

    // Stage payloads
    fpu_mult_pkg::operand_t             op;
    fpu_mult_pkg::round_mode_e          round_mode;
    fpu_mult_pkg::round_res_t           res;
    logic [47:0]                        product;
    logic [fpu_mult_pkg::EXP_W-1:0]     exp_res;
    logic                               exp_ovf;
    logic                               exp_unf;

    ////////////////////////////////////////
    // Input side and controller
    ////////////////////////////////////////

    fpu_operand_stage u_operand_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .load_i       (load_op),
        .data_x_i     (data_x_i),
        .data_y_i     (data_y_i),
        .round_mode_i (round_mode_i),
        .op_o         (op),
        .round_mode_o (round_mode)
    );

    fpu_mult_ctrl u_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .beg_i       (beg_i),
        .ack_i       (ack_i),
        .zero_i      (op.zero),
        .mul_done_i  (mul_done),
        .load_op_o   (load_op),
        .mul_start_o (mul_start),
        .norm_load_o (norm_load),
        .exp_load_o  (exp_load),
        .pack_load_o (pack_load),
        .ready_o     (ready_o)
    );

    ////////////////////////////////////////
    // Significand path
    ////////////////////////////////////////

    fpu_sgf_multiplier u_sgf_mult (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (mul_start),
        .sgf_x_i   (op.sgf_x),
        .sgf_y_i   (op.sgf_y),
        .product_o (product),
        .done_o    (mul_done)
    );

    fpu_norm_round u_norm_round (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .load_i       (norm_load),
        .product_i    (product),
        .sign_i       (op.sign),
        .round_mode_i (round_mode),
        .res_o        (res)
    );

    ////////////////////////////////////////
    // Exponent and output side
    ////////////////////////////////////////

    fpu_exp_unit u_exp_unit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .load_i      (exp_load),
        .op_i        (op),
        .res_i       (res),
        .exp_o       (exp_res),
        .overflow_o  (exp_ovf),
        .underflow_o (exp_unf)
    );

    fpu_result_pack u_result_pack (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .load_i      (pack_load),
        .sign_i      (op.sign),
        .zero_i      (op.zero),
        .exp_i       (exp_res),
        .frac_i      (res.frac),
        .overflow_i  (exp_ovf),
        .underflow_i (exp_unf),
        .result_o    (result_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

endmodule

// File: fpu_mult_tb.sv
module fpu_mult_tb;

    // Run length, directed ops include the two rounding-carry cases
    localparam int N_DIRECTED  = 13;
    localparam int N_RAND      = 200;
    localparam int N_BP        = 20;
    localparam int OP_COUNT    = N_DIRECTED + 4 * N_RAND + N_BP;
    localparam int CYCLE_LIMIT = 40 * OP_COUNT + 100;

    logic        clk;
    logic        rst_n_i;
    logic        beg_i;
    logic        ack_i;
    logic [31:0] data_x_i;
    logic [31:0] data_y_i;
    logic [31:0] result_o;
    logic        overflow_o;
    logic        underflow_o;
    logic        ready_o;
    fpu_mult_pkg::round_mode_e round_mode_i;

    // Expected response of the operation in flight
    logic [31:0] exp_result;
    logic        exp_ovf;
    logic        exp_unf;
    int          exp_lat;

    // Handshake tracking
    logic        in_flight = 1'b0;
    logic        rst_seen  = 1'b0;
    int          lat_cnt   = 0;
    int          cycle_cnt = 0;

    // Bookkeeping
    integer      seed;
    int          errors;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;

    fpu_mult_top uut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .beg_i        (beg_i),
        .ack_i        (ack_i),
        .data_x_i     (data_x_i),
        .data_y_i     (data_y_i),
        .round_mode_i (round_mode_i),
        .result_o     (result_o),
        .overflow_o   (overflow_o),
        .underflow_o  (underflow_o),
        .ready_o      (ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // Handshake tracking and timeout
    ////////////////////////////////////////

    // Cycles from accepted beg_i until ready_o
    always @(posedge clk) begin
        if (!rst_n_i) begin
            in_flight <= 1'b0;
            lat_cnt   <= 0;
            rst_seen  <= 1'b1;
        end else if (beg_i && !in_flight) begin
            in_flight <= 1'b1;
            lat_cnt   <= 0;
        end else if (in_flight && ready_o && ack_i) begin
            in_flight <= 1'b0;
        end else if (in_flight && !ready_o) begin
            lat_cnt <= lat_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic log_mismatch(input string name, input logic [31:0] expv,
                                input logic [31:0] got);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, expv, got);
        errors = errors + 1;
    endtask

    task automatic log_failure(input string what);
        $display("%0t: %s", $time, what);
        errors = errors + 1;
    endtask

    ////////////////////////////////////////
    // Checkers
    ////////////////////////////////////////

    // Synchronous reset, so look only after the first reset edge
    a_reset_clear: assert property (@(posedge clk)
        (!rst_n_i && rst_seen) |->
            (!ready_o && result_o == '0 && !overflow_o && !underflow_o))
        else log_failure("outputs not cleared during reset");

    a_lat_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_flight |-> lat_cnt <= 32)
        else log_failure("ready_o did not rise within 32 cycles of beg_i");

    a_lat_exact: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ready_o) |-> lat_cnt == exp_lat)
        else log_mismatch("latency", exp_lat, $sampled(lat_cnt));

    a_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ready_o) |-> result_o == exp_result)
        else log_mismatch("result_o", exp_result, $sampled(result_o));

    a_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ready_o) |-> overflow_o == exp_ovf)
        else log_mismatch("overflow_o", exp_ovf, $sampled(overflow_o));

    a_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ready_o) |-> underflow_o == exp_unf)
        else log_mismatch("underflow_o", exp_unf, $sampled(underflow_o));

    // Held result under back-pressure
    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ready_o && !ack_i) |=> (ready_o && $stable(result_o)
            && $stable(overflow_o) && $stable(underflow_o)))
        else log_failure("outputs changed while the result was held");

    a_release: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ready_o && ack_i) |=> !ready_o)
        else log_failure("ready_o did not fall one cycle after ack_i");

    // A beg_i while busy or ready must not start a second operation
    a_no_stray: assert property (@(posedge clk) disable iff (!rst_n_i)
        !in_flight |-> !ready_o)
        else log_failure("ready_o high with no operation accepted");

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic compute_expected(input logic [31:0] x, input logic [31:0] y,
                                    input logic [1:0] rm, output logic [31:0] res,
                                    output logic ovf, output logic unf, output int lat);
        logic [47:0] p;
        logic [23:0] m;
        logic [24:0] lost;
        logic [24:0] half;
        logic [24:0] m_up;
        logic        sign;
        logic        up;
        int          e;
        sign = x[31] ^ y[31];
        ovf  = 1'b0;
        unf  = 1'b0;
        if (x[30:23] == 8'd0 || y[30:23] == 8'd0) begin
            // Zero or subnormal operand
            res = {sign, 31'd0};
            lat = 3;
        end else begin
            lat = 28;
            p = 48'({1'b1, x[22:0]}) * 48'({1'b1, y[22:0]});
            e = int'(x[30:23]) + int'(y[30:23]) - fpu_mult_pkg::BIAS;
            // Dropped bits compared against half an ulp
            if (p[47]) begin
                m    = p[47:24];
                lost = {1'b0, p[23:0]};
                half = 25'h0800000;
                e    = e + 1;
            end else begin
                m    = p[46:23];
                lost = {2'b00, p[22:0]};
                half = 25'h0400000;
            end
            case (rm)
                fpu_mult_pkg::RM_NEAREST_EVEN: up = (lost > half) || (lost == half && m[0]);
                fpu_mult_pkg::RM_TO_ZERO:      up = 1'b0;
                fpu_mult_pkg::RM_TO_POS:       up = !sign && (lost != 0);
                default:                       up = sign && (lost != 0);
            endcase
            m_up = {1'b0, m} + 25'(up);
            // Significand reached 2.0
            if (m_up[24]) begin
                e    = e + 1;
                m_up = 25'h0800000;
            end
            if (e >= 255) begin
                res = {sign, 8'hff, 23'd0};
                ovf = 1'b1;
            end else if (e <= 0) begin
                res = {sign, 31'd0};
                unf = 1'b1;
            end else begin
                res = {sign, 8'(e), m_up[22:0]};
            end
        end
    endtask

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    // One full operation, optional beg_i pulses while busy and while ready
    task automatic run_op(input logic [31:0] x, input logic [31:0] y, input logic [1:0] rm,
                          input int ack_delay, input bit poke);
        int wait_cnt;
        compute_expected(x, y, rm, exp_result, exp_ovf, exp_unf, exp_lat);
        @(posedge clk);
        #2;
        data_x_i     = x;
        data_y_i     = y;
        round_mode_i = fpu_mult_pkg::round_mode_e'(rm);
        beg_i        = 1'b1;
        @(posedge clk);
        #2;
        beg_i = 1'b0;
        // Operands must already be captured
        data_x_i     = $random(seed);
        data_y_i     = $random(seed);
        round_mode_i = fpu_mult_pkg::round_mode_e'($random(seed));
        wait_cnt = 0;
        while (!ready_o) begin
            @(posedge clk);
            #2;
            wait_cnt = wait_cnt + 1;
            beg_i = poke && (wait_cnt == 5);
        end
        beg_i = 1'b0;
        if (poke) begin
            beg_i = 1'b1;
            @(posedge clk);
            #2;
            beg_i = 1'b0;
        end
        repeat (ack_delay) begin
            @(posedge clk);
            #2;
        end
        ack_i = 1'b1;
        @(posedge clk);
        #2;
        ack_i = 1'b0;
    endtask

    // Directed case with a hand-worked result word
    task automatic check_known(input logic [31:0] x, input logic [31:0] y,
                               input logic [1:0] rm, input logic [31:0] known);
        run_op(x, y, rm, 0, 1'b0);
        if (result_o !== known) begin
            log_mismatch("result_o", known, result_o);
        end
    endtask

    // Exponent kept mid-range so most products stay normal
    task automatic draw_operand(output logic [31:0] w);
        logic [7:0] e;
        e = 8'd64 + 8'($unsigned($random(seed)) % 128);
        w = {1'($random(seed)), e, 23'($random(seed))};
    endtask

    task automatic begin_test();
        err_mark = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            pass_cnt = pass_cnt + 1;
            $display("test %-24s PASS", name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("test %-24s FAIL (%0d errors)", name, errors - err_mark);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        int          i;
        int          m;
        rst_n_i      = 1'b0;
        beg_i        = 1'b0;
        ack_i        = 1'b0;
        data_x_i     = '0;
        data_y_i     = '0;
        round_mode_i = fpu_mult_pkg::RM_NEAREST_EVEN;
        seed         = 76;
        errors       = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        repeat (8) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        begin_test();
        run_op(32'h3fc0_0000, 32'h4040_0000, 2'd0, 0, 1'b1);
        end_test("reset_and_busy_beg");

        // 1.5*2, -3*0.5, 1*1
        begin_test();
        check_known(32'h3fc0_0000, 32'h4000_0000, 2'd0, 32'h4040_0000);
        check_known(32'hc040_0000, 32'h3f00_0000, 2'd1, 32'hbfc0_0000);
        check_known(32'h3f80_0000, 32'h3f80_0000, 2'd2, 32'h3f80_0000);
        end_test("directed_normal");

        // Zero, negative zero, subnormal
        begin_test();
        check_known(32'h0000_0000, 32'h3fc0_0000, 2'd0, 32'h0000_0000);
        check_known(32'h8000_0000, 32'h3f80_0000, 2'd3, 32'h8000_0000);
        check_known(32'h0000_0123, 32'hbf80_0000, 2'd0, 32'h8000_0000);
        end_test("zero_operand");

        begin_test();
        check_known(32'h7f00_0000, 32'h4000_0000, 2'd0, 32'h7f80_0000);
        check_known(32'hff00_0000, 32'h7f00_0000, 2'd1, 32'hff80_0000);
        check_known(32'h0080_0000, 32'h3f00_0000, 2'd0, 32'h0000_0000);
        check_known(32'h8080_0000, 32'h3f00_0000, 2'd2, 32'h8000_0000);
        end_test("overflow_underflow");

        // sqrt(2) squared sits just under 2.0, upward rounding carries
        begin_test();
        check_known(32'h3fb5_04f3, 32'h3fb5_04f3, 2'd0, 32'h3fff_ffff);
        check_known(32'h3fb5_04f3, 32'h3fb5_04f3, 2'd2, 32'h4000_0000);
        for (i = 0; i < N_RAND; i++) begin
            draw_operand(a);
            draw_operand(b);
            for (m = 0; m < 4; m++) begin
                run_op(a, b, 2'(m), 0, 1'b0);
            end
        end
        end_test("random_all_modes");

        begin_test();
        for (i = 0; i < N_BP; i++) begin
            draw_operand(a);
            draw_operand(b);
            run_op(a, b, 2'($random(seed)), $unsigned($random(seed)) % 11, 1'b0);
        end
        end_test("back_pressure");

        $display("tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim.f
fpu_mult_pkg.sv
fpu_operand_stage.sv
fpu_exp_unit.sv
fpu_sgf_multiplier.sv
fpu_norm_round.sv
fpu_result_pack.sv
fpu_mult_ctrl.sv
fpu_mult_top.sv
fpu_mult_tb.sv
